// ==== verilog/beam_config.svh ====
`ifndef BEAM_CONFIG_SVH
`define BEAM_CONFIG_SVH

// sizing of the receive beamformer datapath
// every width below is referenced through these macros so a change here
// ripples through the package types and both arithmetic stages

// number of complex samples carried in one input or output beat
`define BEAM_LANES 8

// width of one real or one imaginary sample part, two's complement
`define BEAM_SAMPLE_WIDTH 16

// width of one real or one imaginary weight part, two's complement
`define BEAM_WEIGHT_WIDTH 8

// the weights are Q1.7, so a product is scaled back by this many bits
// a weight of 127 is just under unity gain and -128 is exactly minus one
`define BEAM_WEIGHT_FRAC 7

// derived widths used by the arithmetic stages
// a full sample times weight product needs the sum of both widths
`define BEAM_PRODUCT_WIDTH (`BEAM_SAMPLE_WIDTH + `BEAM_WEIGHT_WIDTH)

// the difference or sum of two products needs one bit of headroom
`define BEAM_CROSS_WIDTH (`BEAM_PRODUCT_WIDTH + 1)

// the combiner adds two samples, so one extra bit keeps the sum exact
`define BEAM_SUM_WIDTH (`BEAM_SAMPLE_WIDTH + 1)

`endif

// ==== verilog/beam_pkg.sv ====
`include "beam_config.svh"

// shared types for the beamformer datapath
package beam_pkg;

    // one signed real or imaginary sample part
    typedef logic signed [`BEAM_SAMPLE_WIDTH-1:0] sample_t;

    // one signed real or imaginary weight part in Q1.7
    typedef logic signed [`BEAM_WEIGHT_WIDTH-1:0] weight_t;

    // full precision product of a sample part and a weight part
    typedef logic signed [`BEAM_PRODUCT_WIDTH-1:0] product_t;

    // difference or sum of two products before scaling
    typedef logic signed [`BEAM_CROSS_WIDTH-1:0] cross_t;

    // lane-wise sum of two channels before halving
    typedef logic signed [`BEAM_SUM_WIDTH-1:0] sum_t;

    // all lanes of one part of a beat, lane 0 sits in the low bits
    typedef sample_t [`BEAM_LANES-1:0] lanes_t;

    // real and imaginary lanes of one beat travel side by side
    typedef struct packed {
        lanes_t re;
        lanes_t im;
    } complex_beat_t;

    // complex weight applied to every lane of a channel
    typedef struct packed {
        weight_t re;
        weight_t im;
    } complex_weight_t;

    // payload of every stream in the design
    // valid is carried next to it as a separate strobe
    typedef struct packed {
        logic          last;
        complex_beat_t data;
    } chan_beat_t;

endpackage

// ==== verilog/channel_weighter.sv ====
`timescale 1ns/1ps
`include "beam_config.svh"

// complex weighting of one antenna channel
// every lane is multiplied by the channel weight in two pipeline stages
// stage 1 holds the four partial products and stage 2 holds the scaled result
module channel_weighter import beam_pkg::*; (
    input  logic            clock,
    input  logic            resetn,
    input  logic            valid,
    input  chan_beat_t      beat,
    input  complex_weight_t weight,
    output logic            weighted_valid,
    output chan_beat_t      weighted_beat
);

    // stage 1 control, the valid strobe and the last flag of the captured beat
    logic s1_valid;
    logic s1_last;

    // stage 1 partial products per lane
    // rr is sr*wr, ii is si*wi, ri is sr*wi and ir is si*wr
    product_t [`BEAM_LANES-1:0] prod_rr;
    product_t [`BEAM_LANES-1:0] prod_ii;
    product_t [`BEAM_LANES-1:0] prod_ri;
    product_t [`BEAM_LANES-1:0] prod_ir;

    // signed multiply at full product width
    // both operands are sign extended first so no bit of the result is lost
    function automatic product_t mult(input sample_t sample, input weight_t coef);
        product_t sample_ext;
        product_t coef_ext;
        sample_ext = product_t'(sample);
        coef_ext = product_t'(coef);
        return sample_ext * coef_ext;
    endfunction

    // drop the Q1.7 fraction and wrap to one sample
    // the shift is arithmetic, so the result rounds toward minus infinity
    // bits above the sample width are discarded, which gives the wrap
    function automatic sample_t scale_wrap(input cross_t value);
        cross_t shifted;
        shifted = value >>> `BEAM_WEIGHT_FRAC;
        return sample_t'(shifted[`BEAM_SAMPLE_WIDTH-1:0]);
    endfunction

    // stage 1 captures the products in the cycle the input is valid
    // the weight is a level and is only looked at in that same cycle
    always_ff @(posedge clock) begin
        if (!resetn) begin
            s1_valid <= 1'b0;
            s1_last <= 1'b0;
            prod_rr <= '0;
            prod_ii <= '0;
            prod_ri <= '0;
            prod_ir <= '0;
        end else begin
            s1_valid <= valid;
            // products only move on a valid beat, otherwise they hold
            if (valid) begin
                s1_last <= beat.last;
                for (int lane = 0; lane < `BEAM_LANES; lane++) begin
                    prod_rr[lane] <= mult(beat.data.re[lane], weight.re);
                    prod_ii[lane] <= mult(beat.data.im[lane], weight.im);
                    prod_ri[lane] <= mult(beat.data.re[lane], weight.im);
                    prod_ir[lane] <= mult(beat.data.im[lane], weight.re);
                end
            end
        end
    end

    // stage 2 forms the complex product from the partial products
    // real part is sr*wr - si*wi and imaginary part is sr*wi + si*wr
    // both are taken at one extra bit so the cross term cannot overflow
    always_ff @(posedge clock) begin
        if (!resetn) begin
            weighted_valid <= 1'b0;
            weighted_beat <= '0;
        end else begin
            weighted_valid <= s1_valid;
            if (s1_valid) begin
                weighted_beat.last <= s1_last;
                for (int lane = 0; lane < `BEAM_LANES; lane++) begin
                    weighted_beat.data.re[lane] <=
                        scale_wrap(cross_t'(prod_rr[lane]) - cross_t'(prod_ii[lane]));
                    weighted_beat.data.im[lane] <=
                        scale_wrap(cross_t'(prod_ri[lane]) + cross_t'(prod_ir[lane]));
                end
            end
        end
    end

    // the weighted strobe must trail the input strobe by exactly two cycles
    // the check waits until both pipeline stages have left reset
    property p_valid_latency;
        @(posedge clock) disable iff (!resetn)
            ($past(resetn) && $past(resetn, 2)) |-> (weighted_valid == $past(valid, 2));
    endproperty

    a_valid_latency: assert property (p_valid_latency)
        else $error("channel_weighter: weighted_valid is not valid delayed by two cycles");

endmodule

// ==== verilog/beam_combiner.sv ====
`timescale 1ns/1ps
`include "beam_config.svh"

// sums the two weighted channels into one beam
// an idle channel adds zero, and the sum is halved to stay in one sample
module beam_combiner import beam_pkg::*; (
    input  logic       clock,
    input  logic       resetn,
    input  logic       ch0_valid,
    input  logic       ch1_valid,
    input  chan_beat_t ch0_beat,
    input  chan_beat_t ch1_beat,
    output logic       beam_valid,
    output chan_beat_t beam_beat
);

    // channel beats with an invalid channel forced to zero
    chan_beat_t ch0_masked;
    chan_beat_t ch1_masked;

    // combined beat that is registered on the next edge
    chan_beat_t beam_next;

    // add two samples at one extra bit and halve the sum
    // the arithmetic shift truncates toward minus infinity
    // the halved value always fits one sample, so nothing wraps here
    function automatic sample_t half_sum(input sample_t a, input sample_t b);
        sum_t sum;
        sum = sum_t'(a) + sum_t'(b);
        return sample_t'(sum >>> 1);
    endfunction

    // a channel without a valid beat contributes zero and no last flag
    always_comb begin
        ch0_masked = ch0_valid ? ch0_beat : '0;
        ch1_masked = ch1_valid ? ch1_beat : '0;
    end

    // lane-wise sum of the real and imaginary parts
    // last is the OR of the flags that survived the masking
    always_comb begin
        beam_next.last = ch0_masked.last | ch1_masked.last;
        for (int lane = 0; lane < `BEAM_LANES; lane++) begin
            beam_next.data.re[lane] =
                half_sum(ch0_masked.data.re[lane], ch1_masked.data.re[lane]);
            beam_next.data.im[lane] =
                half_sum(ch0_masked.data.im[lane], ch1_masked.data.im[lane]);
        end
    end

    // one register stage for the beam
    // when neither channel is valid the beat loads zero, so last drops too
    always_ff @(posedge clock) begin
        if (!resetn) begin
            beam_valid <= 1'b0;
            beam_beat <= '0;
        end else begin
            beam_valid <= ch0_valid | ch1_valid;
            beam_beat <= beam_next;
        end
    end

    // a last flag may only leave the design on a valid beam beat
    property p_last_needs_valid;
        @(posedge clock) disable iff (!resetn)
            beam_beat.last |-> beam_valid;
    endproperty

    a_last_needs_valid: assert property (p_last_needs_valid)
        else $error("beam_combiner: last is high on a beat without beam_valid");

endmodule

// ==== verilog/beamformer_top.sv ====
`timescale 1ns/1ps

// two channel receive beamformer
// each channel is weighted by its own complex coefficient and the two
// weighted streams are summed into one beam three cycles after the input
module beamformer_top import beam_pkg::*; (
    input  logic            clock,
    input  logic            resetn,
    input  logic            ch0_valid,
    input  logic            ch1_valid,
    input  chan_beat_t      ch0_beat,
    input  chan_beat_t      ch1_beat,
    input  complex_weight_t ch0_weight,
    input  complex_weight_t ch1_weight,
    output logic            beam_valid,
    output chan_beat_t      beam_beat
);

    // weighted streams between the channel weighters and the combiner
    logic       ch0_weighted_valid;
    logic       ch1_weighted_valid;
    chan_beat_t ch0_weighted_beat;
    chan_beat_t ch1_weighted_beat;

    // channel 0 weighting, two cycles of latency
    channel_weighter u_weighter_ch0 (
        .clock          (clock),
        .resetn         (resetn),
        .valid          (ch0_valid),
        .beat           (ch0_beat),
        .weight         (ch0_weight),
        .weighted_valid (ch0_weighted_valid),
        .weighted_beat  (ch0_weighted_beat)
    );

    // channel 1 weighting, identical pipeline so both channels stay aligned
    channel_weighter u_weighter_ch1 (
        .clock          (clock),
        .resetn         (resetn),
        .valid          (ch1_valid),
        .beat           (ch1_beat),
        .weight         (ch1_weight),
        .weighted_valid (ch1_weighted_valid),
        .weighted_beat  (ch1_weighted_beat)
    );

    // both weighters have the same depth, so beats that entered in the
    // same cycle reach the combiner together and are never mixed with
    // beats from another cycle
    beam_combiner u_combiner (
        .clock      (clock),
        .resetn     (resetn),
        .ch0_valid  (ch0_weighted_valid),
        .ch1_valid  (ch1_weighted_valid),
        .ch0_beat   (ch0_weighted_beat),
        .ch1_beat   (ch1_weighted_beat),
        .beam_valid (beam_valid),
        .beam_beat  (beam_beat)
    );

endmodule

// ==== testbench/beam_checker.sv ====
`timescale 1ns/1ps
`include "beam_config.svh"

// scoreboard for the beamformer
// it records the expected beam for every input cycle with a valid channel
// and compares it with the beam that leaves the DUT three cycles later
module beam_checker import beam_pkg::*; (
    input logic            clock,
    input logic            resetn,
    input logic            ch0_valid,
    input logic            ch1_valid,
    input chan_beat_t      ch0_beat,
    input chan_beat_t      ch1_beat,
    input complex_weight_t ch0_weight,
    input complex_weight_t ch1_weight,
    input logic            beam_valid,
    input chan_beat_t      beam_beat
);

    // counters that the testbench reads at the end of each test
    int error_count = 0;
    int checked_count = 0;
    int pending = 0;

    // cycle counter since reset, used to measure the latency of each beam
    int cycle = 0;

    // expected beams in input order, with the cycle each one entered
    chan_beat_t expect_q[$];
    int         cycle_q[$];

    // one lane of one channel times its weight, as plain integers
    // the Q1.7 fraction is dropped by an arithmetic shift and the result wraps to 16 bits
    function automatic void weigh_lane(input chan_beat_t b, input complex_weight_t w,
                                       input int lane, output int re, output int im);
        int sr;
        int si;
        int wr;
        int wi;
        int full_re;
        int full_im;
        sr = b.data.re[lane];
        si = b.data.im[lane];
        wr = w.re;
        wi = w.im;
        full_re = (sr * wr - si * wi) >>> `BEAM_WEIGHT_FRAC;
        full_im = (sr * wi + si * wr) >>> `BEAM_WEIGHT_FRAC;
        re = $signed(full_re[15:0]);
        im = $signed(full_im[15:0]);
    endfunction

    // expected beam of one input cycle, an idle channel adds zero and no last flag
    function automatic chan_beat_t expected_beam(
        input chan_beat_t b0, input complex_weight_t w0, input logic v0,
        input chan_beat_t b1, input complex_weight_t w1, input logic v1);
        chan_beat_t result;
        int re0;
        int im0;
        int re1;
        int im1;
        result.last = (v0 & b0.last) | (v1 & b1.last);
        for (int lane = 0; lane < `BEAM_LANES; lane++) begin
            re0 = 0;
            im0 = 0;
            re1 = 0;
            im1 = 0;
            if (v0)
                weigh_lane(b0, w0, lane, re0, im0);
            if (v1)
                weigh_lane(b1, w1, lane, re1, im1);
            // the sum of two 16-bit values halved always fits 16 bits
            result.data.re[lane] = sample_t'((re0 + re1) >>> 1);
            result.data.im[lane] = sample_t'((im0 + im1) >>> 1);
        end
        return result;
    endfunction

    // compare the current beam with one expected beat, one line per wrong field
    task automatic compare_beat(input chan_beat_t want);
        bit wrong;
        wrong = 1'b0;
        if (beam_beat.last !== want.last) begin
            $display("FAILED at %0t: last is %0b, expected %0b", $time, beam_beat.last, want.last);
            wrong = 1'b1;
        end
        for (int lane = 0; lane < `BEAM_LANES; lane++) begin
            if (beam_beat.data.re[lane] !== want.data.re[lane] ||
                beam_beat.data.im[lane] !== want.data.im[lane]) begin
                $display("FAILED at %0t: lane %0d is (%0d, %0d), expected (%0d, %0d)", $time,
                         lane, beam_beat.data.re[lane], beam_beat.data.im[lane],
                         want.data.re[lane], want.data.im[lane]);
                wrong = 1'b1;
            end
        end
        if (wrong)
            error_count++;
    endtask

    // compare first and push after, so a beat never meets its own expectation
    always @(posedge clock) begin : watch
        chan_beat_t want;
        int sent;
        if (!resetn) begin
            if (beam_valid) begin
                $display("FAILED at %0t: beam_valid is high during reset", $time);
                error_count++;
            end
        end else begin
            cycle++;
            if (beam_valid) begin
                if (expect_q.size() == 0) begin
                    $display("beam_valid went high at %0t with no input beat waiting", $time);
                    error_count++;
                end else begin
                    want = expect_q.pop_front();
                    sent = cycle_q.pop_front();
                    checked_count++;
                    if (cycle - sent != 3) begin
                        $display("FAILED at %0t: latency is %0d cycles, expected 3",
                                 $time, cycle - sent);
                        error_count++;
                    end
                    compare_beat(want);
                end
            end
            if (ch0_valid || ch1_valid) begin
                expect_q.push_back(expected_beam(ch0_beat, ch0_weight, ch0_valid,
                                                 ch1_beat, ch1_weight, ch1_valid));
                cycle_q.push_back(cycle);
            end
            pending = expect_q.size();
        end
    end

endmodule

// ==== testbench/beam_tb.sv ====
`timescale 1ns/1ps
`include "beam_config.svh"

// testbench for the two channel beamformer
// stimulus comes from a Galois LFSR and the checker module does the comparing
module beam_tb import beam_pkg::*; ();

    logic            clock;
    logic            resetn;
    logic            ch0_valid;
    logic            ch1_valid;
    chan_beat_t      ch0_beat;
    chan_beat_t      ch1_beat;
    complex_weight_t ch0_weight;
    complex_weight_t ch1_weight;
    logic            beam_valid;
    chan_beat_t      beam_beat;

    // random source state and run bookkeeping
    logic [15:0] lfsr_state = 16'd13283;
    int          local_errors = 0;
    int          timeout_count = 0;
    int          tests_run = 0;
    int          errors_at_start = 0;

    beamformer_top u_dut (
        .clock      (clock),
        .resetn     (resetn),
        .ch0_valid  (ch0_valid),
        .ch1_valid  (ch1_valid),
        .ch0_beat   (ch0_beat),
        .ch1_beat   (ch1_beat),
        .ch0_weight (ch0_weight),
        .ch1_weight (ch1_weight),
        .beam_valid (beam_valid),
        .beam_beat  (beam_beat)
    );

    beam_checker u_checker (
        .clock      (clock),
        .resetn     (resetn),
        .ch0_valid  (ch0_valid),
        .ch1_valid  (ch1_valid),
        .ch0_beat   (ch0_beat),
        .ch1_beat   (ch1_beat),
        .ch0_weight (ch0_weight),
        .ch1_weight (ch1_weight),
        .beam_valid (beam_valid),
        .beam_beat  (beam_beat)
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;

    // one Galois step with the taps of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0])
            return (state >> 1) ^ 16'hB400;
        return state >> 1;
    endfunction

    // collect n random bits and move the LFSR once for each of them
    function logic [31:0] rand_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // extreme mode only picks the two ends of the range
    function sample_t pick_sample(input bit extreme);
        if (extreme)
            return rand_bits(1) ? 16'h7FFF : 16'h8000;
        return sample_t'(rand_bits(16));
    endfunction

    function weight_t pick_weight(input bit extreme);
        if (extreme)
            return rand_bits(1) ? 8'h7F : 8'h80;
        return weight_t'(rand_bits(8));
    endfunction

    function chan_beat_t random_beat(input bit extreme);
        chan_beat_t b;
        b.last = 1'(rand_bits(1));
        for (int lane = 0; lane < `BEAM_LANES; lane++) begin
            b.data.re[lane] = pick_sample(extreme);
            b.data.im[lane] = pick_sample(extreme);
        end
        return b;
    endfunction

    function complex_weight_t random_weight(input bit extreme);
        complex_weight_t w;
        w.re = pick_weight(extreme);
        w.im = pick_weight(extreme);
        return w;
    endfunction

    // new data and weights on every call and an idle channel still gets random data
    task drive_cycle(input logic v0, input logic v1, input bit extreme);
        @(posedge clock);
        ch0_valid <= v0;
        ch1_valid <= v1;
        ch0_beat <= random_beat(extreme);
        ch1_beat <= random_beat(extreme);
        ch0_weight <= random_weight(extreme);
        ch1_weight <= random_weight(extreme);
    endtask

    task idle_cycle();
        @(posedge clock);
        ch0_valid <= 1'b0;
        ch1_valid <= 1'b0;
    endtask

    function int total_errors();
        return u_checker.error_count + local_errors + timeout_count;
    endfunction

    // status is read on the falling edge clear of the checker's updates
    task wait_drain();
        int waited;
        waited = 0;
        idle_cycle();
        do begin
            @(negedge clock);
            waited++;
        end while (u_checker.pending != 0 && waited < 20);
        if (u_checker.pending != 0) begin
            $display("timeout: %0d expected beam beats never arrived", u_checker.pending);
            timeout_count++;
        end
    endtask

    task start_test();
        errors_at_start = total_errors();
    endtask

    task finish_test(input string name);
        wait_drain();
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, total_errors() - errors_at_start);
    endtask

    initial begin
        int waited;
        resetn = 1'b0;
        ch0_valid = 1'b0;
        ch1_valid = 1'b0;
        ch0_beat = '0;
        ch1_beat = '0;
        ch0_weight = '0;
        ch1_weight = '0;
        // the checker flags any beam_valid seen while reset is low
        repeat (5) @(posedge clock);
        resetn <= 1'b1;

        // quiet after reset and then one beat and its latency
        start_test();
        repeat (4) begin
            @(negedge clock);
            if (beam_valid) begin
                $display("FAILED at %0t: beam_valid is high before any input", $time);
                local_errors++;
            end
        end
        drive_cycle(1'b1, 1'b0, 1'b0);
        idle_cycle();
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (!beam_valid && waited < 10);
        if (!beam_valid) begin
            $display("timeout: no beam_valid after a single input beat");
            timeout_count++;
        end else if (waited != 3) begin
            $display("FAILED at %0t: beam_valid after %0d cycles, expected 3", $time, waited);
            local_errors++;
        end
        finish_test("latency after reset");

        start_test();
        repeat (20) drive_cycle(1'b1, 1'b0, 1'b0);
        finish_test("ch0 only");

        start_test();
        repeat (20) drive_cycle(1'b1, 1'b1, 1'b0);
        finish_test("both channels");

        start_test();
        repeat (50) drive_cycle(1'(rand_bits(1)), 1'(rand_bits(1)), 1'b0);
        finish_test("back to back random valids");

        // random last flags ride on every beat including the idle channels
        start_test();
        repeat (30) drive_cycle(1'(rand_bits(1)), 1'(rand_bits(1)), 1'b0);
        finish_test("last merge");

        start_test();
        repeat (20) drive_cycle(1'b1, 1'(rand_bits(1)), 1'b1);
        finish_test("extreme values");

        $display("tests %0d, beats checked %0d, errors %0d, timeouts %0d", tests_run,
                 u_checker.checked_count, u_checker.error_count + local_errors, timeout_count);
        if (total_errors() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/beam_pkg.sv
verilog/channel_weighter.sv
verilog/beam_combiner.sv
verilog/beamformer_top.sv
testbench/beam_checker.sv
testbench/beam_tb.sv

// ==== Bender.yml ====
package:
  name: beamformer

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/beam_pkg.sv
      - verilog/channel_weighter.sv
      - verilog/beam_combiner.sv
      - verilog/beamformer_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/beam_checker.sv
      - testbench/beam_tb.sv
